// ==== design/axi_bridge_params.svh ====
`ifndef AXI_BRIDGE_PARAMS_SVH
`define AXI_BRIDGE_PARAMS_SVH

// axi bus geometry
`define AXI_DW      32          // data width
`define AXI_AW      32          // address width
`define AXI_IDW     4           // id width on ar

// cache line
`define LINE_W      512
`define LINE_BEATS  16          // LINE_W / AXI_DW

// read ids per requester
`define AXI_ID_INST 4'd0
`define AXI_ID_DATA 4'd1

`endif

// ==== design/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // read channel engine
    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_ADDR,                // ar valid held
        RD_DATA                 // r ready held
    } rd_state_t;

    // write channel engine
    typedef enum logic [1:0]
    {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP                 // waiting on b
    } wr_state_t;

    // owner of the pending read
    typedef enum logic
    {
        REQ_INST,
        REQ_DATA
    } requester_t;

endpackage

// ==== design/rd_req_if.sv ====
`include "axi_bridge_params.svh"

interface rd_req_if;
    import axi_bridge_pkg::*;

    logic               valid;      // latched request pending
    logic [`AXI_AW-1:0] addr;
    requester_t         owner;
    logic               done;       // last r beat taken

    modport source
    (
        output valid, addr, owner,
        input  done
    );

    modport sink
    (
        input  valid, addr, owner,
        output done
    );

endinterface

// ==== design/line_assembler.sv ====
`include "axi_bridge_params.svh"

module line_assembler
(
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_beat,       // r handshake
    input  logic [`AXI_DW-1:0] i_beat_data,
    input  logic               i_last,
    output logic [`LINE_W-1:0] o_line
);

    localparam int STORE_W = `LINE_W - `AXI_DW;    // 15 beats held

    logic [STORE_W-1:0] store_q;

    // new beat enters at the top, first beat ends up at bit 0
    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            store_q <= '0;
        end
        else if (i_beat)
        begin
            if (i_last)
                store_q <= '0;      // ready for the next line
            else
                store_q <= {i_beat_data, store_q[STORE_W-1:`AXI_DW]};
        end
    end

    // valid in the cycle of the last beat
    assign o_line = {i_beat_data, store_q};

endmodule

// ==== design/rd_req_decode.sv ====
`include "axi_bridge_params.svh"

module rd_req_decode
(
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_irvalid,
    input  logic [`AXI_AW-1:0] i_iraddr,
    input  logic               i_drvalid,
    input  logic [`AXI_AW-1:0] i_draddr,
    rd_req_if.source           req
);
    import axi_bridge_pkg::*;

    logic pick_data;
    logic pick_inst;

    // data cache has priority, only sampled while nothing is pending
    assign pick_data = !req.valid && i_drvalid;
    assign pick_inst = !req.valid && !i_drvalid && i_irvalid;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            req.valid <= 1'b0;
            req.owner <= REQ_INST;
        end
        else if (req.done)
        begin
            req.valid <= 1'b0;      // free again next cycle
        end
        else if (pick_data)
        begin
            req.valid <= 1'b1;
            req.owner <= REQ_DATA;
        end
        else if (pick_inst)
        begin
            req.valid <= 1'b1;
            req.owner <= REQ_INST;
        end
    end

    // line address, no reset needed
    always_ff @(posedge aclk)
    begin
        if (pick_data)
            req.addr <= i_draddr;
        else if (pick_inst)
            req.addr <= i_iraddr;
    end

    // the engine reads addr for the whole burst
    a_addr_stable : assert property (@(posedge aclk) disable iff (!aresetn)
        (req.valid && !req.done) |=> $stable(req.addr))
        else $error("rd_req_decode: request address changed while pending");

endmodule

// ==== design/axi_rd_engine.sv ====
`include "axi_bridge_params.svh"

module axi_rd_engine
(
    input  logic                aclk,
    input  logic                aresetn,
    rd_req_if.sink              req,
    output logic [`AXI_IDW-1:0] o_ar_id,
    output logic [`AXI_AW-1:0]  o_ar_addr,
    output logic [7:0]          o_ar_len,
    output logic [2:0]          o_ar_size,
    output logic [1:0]          o_ar_burst,
    output logic                o_ar_valid,
    input  logic                i_ar_ready,
    input  logic [`AXI_DW-1:0]  i_r_data,
    input  logic                i_r_last,
    input  logic                i_r_valid,
    output logic                o_r_ready,
    output logic [`LINE_W-1:0]  o_irdata,
    output logic                o_irready,
    output logic [`LINE_W-1:0]  o_drdata,
    output logic                o_drready
);
    import axi_bridge_pkg::*;

    localparam int BEAT_CW = $clog2(`LINE_BEATS);

    rd_state_t          state_q;
    rd_state_t          state_d;
    logic               r_hs;
    logic               last_hs;
    logic [BEAT_CW-1:0] beat_cnt;
    logic [`LINE_W-1:0] line;

    assign r_hs     = i_r_valid && o_r_ready;
    assign last_hs  = r_hs && i_r_last;
    assign req.done = last_hs;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            state_q <= RD_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (req.valid) state_d = RD_ADDR;
            RD_ADDR: if (i_ar_ready) state_d = RD_DATA;
            RD_DATA: if (last_hs) state_d = RD_IDLE;
            default: state_d = RD_IDLE;
        endcase
    end

    // fixed burst shape: 16 x 4 bytes, incr
    assign o_ar_id    = (req.owner == REQ_DATA) ? `AXI_ID_DATA : `AXI_ID_INST;
    assign o_ar_addr  = req.addr;
    assign o_ar_len   = 8'(`LINE_BEATS - 1);
    assign o_ar_size  = 3'd2;
    assign o_ar_burst = 2'b01;
    assign o_ar_valid = (state_q == RD_ADDR);
    assign o_r_ready  = (state_q == RD_DATA);

    line_assembler u_line_assembler
    (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_beat      (r_hs),
        .i_beat_data (i_r_data),
        .i_last      (i_r_last),
        .o_line      (line)
    );

    // line and pulse go to whoever owns the request
    assign o_irready = last_hs && (req.owner == REQ_INST);
    assign o_drready = last_hs && (req.owner == REQ_DATA);
    assign o_irdata  = o_irready ? line : '0;
    assign o_drdata  = o_drready ? line : '0;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            beat_cnt <= '0;
        else if (last_hs)
            beat_cnt <= '0;
        else if (r_hs)
            beat_cnt <= beat_cnt + 1'b1;
    end

    a_rlast_16th : assert property (@(posedge aclk) disable iff (!aresetn)
        r_hs |-> (i_r_last == (beat_cnt == BEAT_CW'(`LINE_BEATS - 1))))
        else $error("axi_rd_engine: r_last not on beat %0d", `LINE_BEATS);

endmodule

// ==== design/axi_wr_engine.sv ====
`include "axi_bridge_params.svh"

module axi_wr_engine
(
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 i_dwvalid,
    input  logic [`AXI_AW-1:0]   i_dwaddr,
    input  logic [`LINE_W-1:0]   i_dwdata,
    input  logic [`AXI_DW/8-1:0] i_dwstrb,
    output logic                 o_dwready,
    output logic [`AXI_AW-1:0]   o_aw_addr,
    output logic [7:0]           o_aw_len,
    output logic [2:0]           o_aw_size,
    output logic [1:0]           o_aw_burst,
    output logic                 o_aw_valid,
    input  logic                 i_aw_ready,
    output logic [`AXI_DW-1:0]   o_w_data,
    output logic [`AXI_DW/8-1:0] o_w_strb,
    output logic                 o_w_last,
    output logic                 o_w_valid,
    input  logic                 i_w_ready,
    input  logic                 i_b_valid,
    output logic                 o_b_ready
);
    import axi_bridge_pkg::*;

    localparam int BEAT_CW = $clog2(`LINE_BEATS);

    wr_state_t            state_q;
    wr_state_t            state_d;
    logic                 take;
    logic                 w_hs;
    logic [BEAT_CW-1:0]   beat_cnt;
    logic [`AXI_AW-1:0]   addr_q;
    logic [`LINE_W-1:0]   line_q;
    logic [`AXI_DW/8-1:0] strb_q;

    assign take = (state_q == WR_IDLE) && i_dwvalid;
    assign w_hs = o_w_valid && i_w_ready;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            state_q <= WR_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (i_dwvalid) state_d = WR_ADDR;
            WR_ADDR: if (i_aw_ready) state_d = WR_DATA;
            WR_DATA: if (w_hs && o_w_last) state_d = WR_RESP;
            WR_RESP: if (i_b_valid) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    // line and strobe moved to the byte offset of the address
    always_ff @(posedge aclk)
    begin
        if (take)
        begin
            addr_q <= i_dwaddr;
            line_q <= i_dwdata << {i_dwaddr[1:0], 3'b000};
            strb_q <= i_dwstrb << i_dwaddr[1:0];
        end
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            beat_cnt <= '0;
        else if (take)
            beat_cnt <= '0;
        else if (w_hs)
            beat_cnt <= beat_cnt + 1'b1;    // wraps to 0 after beat 15
    end

    assign o_aw_addr  = addr_q;
    assign o_aw_len   = 8'(`LINE_BEATS - 1);
    assign o_aw_size  = 3'd2;
    assign o_aw_burst = 2'b01;
    assign o_aw_valid = (state_q == WR_ADDR);

    // lowest word first
    assign o_w_data  = line_q[beat_cnt * `AXI_DW +: `AXI_DW];
    assign o_w_strb  = strb_q;
    assign o_w_last  = (beat_cnt == BEAT_CW'(`LINE_BEATS - 1));
    assign o_w_valid = (state_q == WR_DATA);

    assign o_b_ready = (state_q == WR_RESP);
    assign o_dwready = o_b_ready && i_b_valid;   // one cycle pulse

    // a stalled beat stays on the bus until the slave takes it
    a_w_stable : assert property (@(posedge aclk) disable iff (!aresetn)
        (o_w_valid && !i_w_ready) |=> o_w_valid && $stable(o_w_data) && $stable(o_w_last))
        else $error("axi_wr_engine: w beat changed before its handshake");

endmodule

// ==== design/cache_axi_bridge.sv ====
`include "axi_bridge_params.svh"

module cache_axi_bridge
(
    input  logic                 aclk,
    input  logic                 aresetn,
    // instruction cache read
    input  logic                 i_irvalid,
    input  logic [`AXI_AW-1:0]   i_iraddr,
    output logic [`LINE_W-1:0]   o_irdata,
    output logic                 o_irready,
    // data cache read
    input  logic                 i_drvalid,
    input  logic [`AXI_AW-1:0]   i_draddr,
    output logic [`LINE_W-1:0]   o_drdata,
    output logic                 o_drready,
    // data cache writeback
    input  logic                 i_dwvalid,
    input  logic [`AXI_AW-1:0]   i_dwaddr,
    input  logic [`LINE_W-1:0]   i_dwdata,
    input  logic [`AXI_DW/8-1:0] i_dwstrb,
    output logic                 o_dwready,
    // ar / r
    output logic [`AXI_IDW-1:0]  o_ar_id,
    output logic [`AXI_AW-1:0]   o_ar_addr,
    output logic [7:0]           o_ar_len,
    output logic [2:0]           o_ar_size,
    output logic [1:0]           o_ar_burst,
    output logic                 o_ar_valid,
    input  logic                 i_ar_ready,
    input  logic [`AXI_DW-1:0]   i_r_data,
    input  logic                 i_r_last,
    input  logic                 i_r_valid,
    output logic                 o_r_ready,
    // aw / w / b
    output logic [`AXI_AW-1:0]   o_aw_addr,
    output logic [7:0]           o_aw_len,
    output logic [2:0]           o_aw_size,
    output logic [1:0]           o_aw_burst,
    output logic                 o_aw_valid,
    input  logic                 i_aw_ready,
    output logic [`AXI_DW-1:0]   o_w_data,
    output logic [`AXI_DW/8-1:0] o_w_strb,
    output logic                 o_w_last,
    output logic                 o_w_valid,
    input  logic                 i_w_ready,
    input  logic                 i_b_valid,
    output logic                 o_b_ready
);

    rd_req_if rd_req ();

    rd_req_decode u_rd_req_decode
    (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_irvalid (i_irvalid),
        .i_iraddr  (i_iraddr),
        .i_drvalid (i_drvalid),
        .i_draddr  (i_draddr),
        .req       (rd_req)
    );

    axi_rd_engine u_axi_rd_engine
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req        (rd_req),
        .o_ar_id    (o_ar_id),
        .o_ar_addr  (o_ar_addr),
        .o_ar_len   (o_ar_len),
        .o_ar_size  (o_ar_size),
        .o_ar_burst (o_ar_burst),
        .o_ar_valid (o_ar_valid),
        .i_ar_ready (i_ar_ready),
        .i_r_data   (i_r_data),
        .i_r_last   (i_r_last),
        .i_r_valid  (i_r_valid),
        .o_r_ready  (o_r_ready),
        .o_irdata   (o_irdata),
        .o_irready  (o_irready),
        .o_drdata   (o_drdata),
        .o_drready  (o_drready)
    );

    // writes run independently of reads
    axi_wr_engine u_axi_wr_engine
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_dwvalid  (i_dwvalid),
        .i_dwaddr   (i_dwaddr),
        .i_dwdata   (i_dwdata),
        .i_dwstrb   (i_dwstrb),
        .o_dwready  (o_dwready),
        .o_aw_addr  (o_aw_addr),
        .o_aw_len   (o_aw_len),
        .o_aw_size  (o_aw_size),
        .o_aw_burst (o_aw_burst),
        .o_aw_valid (o_aw_valid),
        .i_aw_ready (i_aw_ready),
        .o_w_data   (o_w_data),
        .o_w_strb   (o_w_strb),
        .o_w_last   (o_w_last),
        .o_w_valid  (o_w_valid),
        .i_w_ready  (i_w_ready),
        .i_b_valid  (i_b_valid),
        .o_b_ready  (o_b_ready)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
`include "axi_bridge_params.svh"

module axi_mem_model
(
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic [`AXI_AW-1:0]   i_ar_addr,
    input  logic                 i_ar_valid,
    output logic                 o_ar_ready,
    output logic [`AXI_DW-1:0]   o_r_data,
    output logic                 o_r_last,
    output logic                 o_r_valid,
    input  logic                 i_r_ready,
    input  logic [`AXI_AW-1:0]   i_aw_addr,
    input  logic                 i_aw_valid,
    output logic                 o_aw_ready,
    input  logic [`AXI_DW-1:0]   i_w_data,
    input  logic [`AXI_DW/8-1:0] i_w_strb,
    input  logic                 i_w_last,
    input  logic                 i_w_valid,
    output logic                 o_w_ready,
    output logic                 o_b_valid,
    input  logic                 i_b_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`AXI_DW-1:0] mem [0:1023];   // 4 KiB, word addressed
    logic               rd_busy;
    logic [9:0]         rd_word;
    logic [7:0]         rd_left;        // beats still to present
    logic [1:0]         wr_phase;       // 0 aw, 1 w, 2 b
    logic [9:0]         wr_word;

    // true except about once in odds calls
    function automatic bit no_stall(input int unsigned odds);
        return ($urandom % odds) != 0;
    endfunction

    initial
    begin
        void'($urandom(32'h537e));
    end

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
            o_r_last   <= 1'b0;
            o_r_data   <= '0;
            rd_busy    <= 1'b0;
            rd_word    <= '0;
            rd_left    <= '0;
        end
        else if (!rd_busy)
        begin
            if (i_ar_valid && o_ar_ready)
            begin
                rd_busy    <= 1'b1;
                rd_word    <= i_ar_addr[11:2];
                rd_left    <= 8'(`LINE_BEATS - 1);
                o_ar_ready <= 1'b0;
            end
            else
                o_ar_ready <= no_stall(4);
        end
        else if (!o_r_valid || i_r_ready)
        begin
            if (o_r_valid && o_r_last)
            begin
                rd_busy   <= 1'b0;      // burst finished
                o_r_valid <= 1'b0;
            end
            else if (no_stall(3))
            begin
                o_r_valid <= 1'b1;
                o_r_data  <= mem[rd_word];
                o_r_last  <= (rd_left == 8'd0);
                rd_word   <= rd_word + 10'd1;
                rd_left   <= rd_left - 8'd1;
            end
            else
                o_r_valid <= 1'b0;
        end
    end

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_b_valid  <= 1'b0;
            wr_phase   <= 2'd0;
            wr_word    <= '0;
            for (int i = 0; i < 1024; i++)
                mem[10'(i)] <= 32'(i) * 32'h9e37_79b1 ^ 32'h0f1e_2d3c;
        end
        else
        begin
            case (wr_phase)
                2'd0:
                    if (i_aw_valid && o_aw_ready)
                    begin
                        wr_word    <= i_aw_addr[11:2];     // unaligned start rounds down
                        wr_phase   <= 2'd1;
                        o_aw_ready <= 1'b0;
                    end
                    else
                        o_aw_ready <= no_stall(3);
                2'd1:
                begin
                    if (i_w_valid && o_w_ready)
                    begin
                        for (int b = 0; b < 4; b++)
                            if (i_w_strb[b])
                                mem[wr_word][b*8 +: 8] <= i_w_data[b*8 +: 8];
                        wr_word <= wr_word + 10'd1;
                        if (i_w_last)
                            wr_phase <= 2'd2;
                    end
                    o_w_ready <= !(i_w_valid && o_w_ready && i_w_last) && no_stall(3);
                end
                default:
                    if (o_b_valid && i_b_ready)
                    begin
                        o_b_valid <= 1'b0;
                        wr_phase  <= 2'd0;
                    end
                    else
                        o_b_valid <= o_b_valid || no_stall(2);
            endcase
        end
    end

endmodule

// ==== sim/tb_cache_axi_bridge.sv ====
`include "axi_bridge_params.svh"

module tb_cache_axi_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {K_IREAD, K_DREAD, K_BOTH, K_WRITE} kind_t;

    typedef struct packed
    {
        kind_t       kind;
        logic [31:0] iaddr;
        logic [31:0] daddr;     // data read or writeback address
        logic [31:0] seed;      // writeback line pattern
        logic [3:0]  strb;
    } entry_t;

    localparam int NUM_ENTRIES = 13;
    localparam int MAX_CYCLES  = 400 * NUM_ENTRIES;

    logic                 aclk;
    logic                 aresetn;
    logic                 i_irvalid, i_drvalid, i_dwvalid;
    logic [`AXI_AW-1:0]   i_iraddr, i_draddr, i_dwaddr;
    logic [`LINE_W-1:0]   i_dwdata, o_irdata, o_drdata;
    logic [`AXI_DW/8-1:0] i_dwstrb, o_w_strb, exp_strb;
    logic                 o_irready, o_drready, o_dwready;
    logic [`AXI_IDW-1:0]  o_ar_id;
    logic [`AXI_AW-1:0]   o_ar_addr, o_aw_addr;
    logic [7:0]           o_ar_len, o_aw_len;
    logic [2:0]           o_ar_size, o_aw_size;
    logic [1:0]           o_ar_burst, o_aw_burst;
    logic                 o_ar_valid, i_ar_ready, o_aw_valid, i_aw_ready;
    logic [`AXI_DW-1:0]   i_r_data, o_w_data;
    logic                 i_r_last, i_r_valid, o_r_ready;
    logic                 o_w_last, o_w_valid, i_w_ready, i_b_valid, o_b_ready;

    logic [`AXI_DW-1:0] ref_mem [0:1023];
    entry_t             stim [NUM_ENTRIES];
    int                 cycles;
    int                 chk_errors;
    int                 mon_errors;
    int                 ir_pulses;
    int                 dr_pulses;
    int                 dw_pulses;

    cache_axi_bridge dut (.*);

    axi_mem_model u_mem
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ar_addr  (o_ar_addr),
        .i_ar_valid (o_ar_valid),
        .o_ar_ready (i_ar_ready),
        .o_r_data   (i_r_data),
        .o_r_last   (i_r_last),
        .o_r_valid  (i_r_valid),
        .i_r_ready  (o_r_ready),
        .i_aw_addr  (o_aw_addr),
        .i_aw_valid (o_aw_valid),
        .o_aw_ready (i_aw_ready),
        .i_w_data   (o_w_data),
        .i_w_strb   (o_w_strb),
        .i_w_last   (o_w_last),
        .i_w_valid  (o_w_valid),
        .o_w_ready  (i_w_ready),
        .o_b_valid  (i_b_valid),
        .i_b_ready  (o_b_ready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // run limit scales with the table length
    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, a cache request never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] fill_word(input int idx);
        return 32'(idx) * 32'h9e37_79b1 ^ 32'h0f1e_2d3c;
    endfunction

    function automatic logic [`LINE_W-1:0] spread_seed(input logic [31:0] seed);
        logic [`LINE_W-1:0] line;
        for (int k = 0; k < `LINE_BEATS; k++)
            line[k*32 +: 32] = seed ^ (32'(k) * 32'h0101_0101);
        return line;
    endfunction

    // word k of the line sits at bits k*32
    function automatic logic [`LINE_W-1:0] expected_line(input logic [31:0] addr);
        logic [`LINE_W-1:0] line;
        for (int k = 0; k < `LINE_BEATS; k++)
            line[k*32 +: 32] = ref_mem[addr[11:2] + 10'(k)];
        return line;
    endfunction

    // request strobe bit j lands on byte lane j + offset, lanes past 3 drop out
    function automatic logic [3:0] lane_strobe(input logic [3:0] strb, input logic [1:0] off);
        logic [3:0] lanes;
        lanes = '0;
        for (int j = 0; j < 4; j++)
            if (strb[j] && j + int'(off) < 4)
                lanes[j + int'(off)] = 1'b1;
        return lanes;
    endfunction

    // line bytes and strobe both move up by the byte offset
    task automatic commit_writeback(input logic [31:0] addr, input logic [`LINE_W-1:0] line,
                                    input logic [3:0] strb);
        logic [3:0] sh;
        int         src;
        sh = lane_strobe(strb, addr[1:0]);
        for (int k = 0; k < `LINE_BEATS; k++)
            for (int b = 0; b < 4; b++)
                if (sh[b])
                begin
                    src = k * 4 + b - int'(addr[1:0]);
                    ref_mem[addr[11:2] + 10'(k)][b*8 +: 8] = line[src*8 +: 8];
                end
    endtask

    task automatic check_that(input bit ok, input string what);
        assert (ok)
        else
        begin
            $display("Error: %0d ns: %s", $time, what);
            chk_errors++;
        end
    endtask

    task automatic check_quiet(input string when);
        @(negedge aclk);
        check_that(!(o_ar_valid || o_r_ready || o_aw_valid || o_w_valid || o_b_ready
                     || o_irready || o_drready || o_dwready),
                   $sformatf("bridge valid or ready high %s", when));
    endtask

    assign exp_strb = lane_strobe(i_dwstrb, i_dwaddr[1:0]);

    always @(negedge aclk)
    begin
        if (aresetn)
        begin
            if (o_irready)
                ir_pulses <= ir_pulses + 1;
            if (o_drready)
                dr_pulses <= dr_pulses + 1;
            if (o_dwready)
                dw_pulses <= dw_pulses + 1;
            if (o_ar_valid && i_ar_ready)
            begin
                // data cache owns the bus while it asks
                assert (o_ar_id == (i_drvalid ? `AXI_ID_DATA : `AXI_ID_INST)
                        && o_ar_addr == (i_drvalid ? i_draddr : i_iraddr))
                else
                begin
                    $display("Error: %0d ns: AR id %0d addr %h not the expected requester",
                             $time, o_ar_id, o_ar_addr);
                    mon_errors++;
                end
                // one line is 16 beats of 4 bytes, incrementing
                assert (o_ar_len == 8'd15 && o_ar_size == 3'd2 && o_ar_burst == 2'b01)
                else
                begin
                    $display("Error: %0d ns: AR len %0d size %0d burst %b not a line burst",
                             $time, o_ar_len, o_ar_size, o_ar_burst);
                    mon_errors++;
                end
            end
            if (o_aw_valid && i_aw_ready)
            begin
                assert (o_aw_addr == i_dwaddr && o_aw_len == 8'd15 && o_aw_size == 3'd2
                        && o_aw_burst == 2'b01)
                else
                begin
                    $display("Error: %0d ns: AW addr %h len %0d size %0d burst %b not as asked",
                             $time, o_aw_addr, o_aw_len, o_aw_size, o_aw_burst);
                    mon_errors++;
                end
            end
            if (o_w_valid && i_w_ready)
            begin
                assert (o_w_strb == exp_strb)
                else
                begin
                    $display("Error: %0d ns: W strobe %b, expected %b",
                             $time, o_w_strb, exp_strb);
                    mon_errors++;
                end
            end
        end
    end

    task automatic run_entry(input entry_t e);
        bit pend_i;
        bit pend_d;
        bit pend_w;
        bit want_i;
        bit want_d;
        bit want_w;
        int ir0, dr0, dw0;
        want_i = (e.kind == K_IREAD || e.kind == K_BOTH);
        want_d = (e.kind == K_DREAD || e.kind == K_BOTH);
        want_w = (e.kind == K_WRITE);
        pend_i = want_i;
        pend_d = want_d;
        pend_w = want_w;
        ir0 = ir_pulses;
        dr0 = dr_pulses;
        dw0 = dw_pulses;
        @(posedge aclk);
        i_irvalid <= pend_i;
        i_iraddr  <= e.iaddr;
        i_drvalid <= pend_d;
        i_draddr  <= e.daddr;
        i_dwvalid <= pend_w;
        i_dwaddr  <= e.daddr;
        i_dwdata  <= spread_seed(e.seed);
        i_dwstrb  <= e.strb;
        while (pend_i || pend_d || pend_w)
        begin
            @(negedge aclk);
            if (o_drready)
            begin
                check_that(o_drdata == expected_line(e.daddr),
                           $sformatf("data cache line at %h differs", e.daddr));
                pend_d = 1'b0;
            end
            if (o_irready)
            begin
                check_that(!pend_d, "instruction cache served before the data cache");
                check_that(o_irdata == expected_line(e.iaddr),
                           $sformatf("instruction cache line at %h differs", e.iaddr));
                pend_i = 1'b0;
            end
            if (o_dwready)
            begin
                commit_writeback(e.daddr, spread_seed(e.seed), e.strb);
                pend_w = 1'b0;
            end
            @(posedge aclk);
            i_irvalid <= pend_i;
            i_drvalid <= pend_d;
            i_dwvalid <= pend_w;
        end
        repeat (2) @(negedge aclk);
        check_that(ir_pulses - ir0 == int'(want_i), "o_irready pulse count wrong");
        check_that(dr_pulses - dr0 == int'(want_d), "o_drready pulse count wrong");
        check_that(dw_pulses - dw0 == int'(want_w), "o_dwready pulse count wrong");
        check_quiet("between requests");
    endtask

    initial
    begin
        aresetn   = 1'b0;
        i_irvalid = 1'b0;
        i_iraddr  = '0;
        i_drvalid = 1'b0;
        i_draddr  = '0;
        i_dwvalid = 1'b0;
        i_dwaddr  = '0;
        i_dwdata  = '0;
        i_dwstrb  = '0;
        for (int i = 0; i < 1024; i++)
            ref_mem[10'(i)] = fill_word(i);
        stim[0]  = '{K_IREAD, 32'h000, 32'h000, 32'h0, 4'h0};
        stim[1]  = '{K_DREAD, 32'h000, 32'h040, 32'h0, 4'h0};
        stim[2]  = '{K_BOTH,  32'h080, 32'h0c0, 32'h0, 4'h0};
        stim[3]  = '{K_WRITE, 32'h000, 32'h100, 32'hcafe_0001, 4'hf};
        stim[4]  = '{K_DREAD, 32'h000, 32'h100, 32'h0, 4'h0};
        stim[5]  = '{K_WRITE, 32'h000, 32'h141, 32'h1234_5678, 4'h5};  // offset 1
        stim[6]  = '{K_DREAD, 32'h000, 32'h140, 32'h0, 4'h0};
        stim[7]  = '{K_BOTH,  32'h100, 32'h140, 32'h0, 4'h0};
        stim[8]  = '{K_IREAD, 32'h3c0, 32'h000, 32'h0, 4'h0};
        stim[9]  = '{K_WRITE, 32'h000, 32'h203, 32'h0bad_f00d, 4'h3};
        stim[10] = '{K_DREAD, 32'h000, 32'h200, 32'h0, 4'h0};
        stim[11] = '{K_WRITE, 32'h000, 32'h280, 32'ha5a5_0f0f, 4'hf};
        stim[12] = '{K_IREAD, 32'h280, 32'h000, 32'h0, 4'h0};
        repeat (5) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (3) check_quiet("after reset");
        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(stim[i]);
        $display("%0d entries run: %0d check errors, %0d bus errors",
                 NUM_ENTRIES, chk_errors, mon_errors);
        if (chk_errors + mon_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/axi_bridge_pkg.sv
design/rd_req_if.sv
design/line_assembler.sv
design/rd_req_decode.sv
design/axi_rd_engine.sv
design/axi_wr_engine.sv
design/cache_axi_bridge.sv
sim/axi_mem_model.sv
sim/tb_cache_axi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache to axi bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cache_axi_bridge -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
